//--- logic/vga_pkg.sv
// Width typedefs, timing phase enum and register word indices for the VGA peripheral.

package vga_pkg;

    // Horizontal and vertical counts and phase widths.
    typedef logic [9:0] coord_t;

    // Pixel clock divider.
    typedef logic [5:0] div_t;

    // Zoom shift amount.
    typedef logic [2:0] shift_t;

    // Stored pixel, 4 bits per channel, red in the top nibble.
    typedef logic [11:0] rgb12_t;

    // One output colour channel.
    typedef logic [7:0] chan_t;

    // Phase order within a line or a frame.
    typedef enum logic [1:0] {
        ph_video = 2'd0,
        ph_fp    = 2'd1,
        ph_sync  = 2'd2,
        ph_bp    = 2'd3
    } phase_e;

    // Configuration register word indices.
    localparam logic [3:0] reg_ctrl   = 4'd0;
    localparam logic [3:0] reg_shift  = 4'd1;
    localparam logic [3:0] reg_h_fp   = 4'd2;
    localparam logic [3:0] reg_h_vid  = 4'd3;
    localparam logic [3:0] reg_h_sync = 4'd4;
    localparam logic [3:0] reg_h_bp   = 4'd5;
    localparam logic [3:0] reg_v_fp   = 4'd6;
    localparam logic [3:0] reg_v_vid  = 4'd7;
    localparam logic [3:0] reg_v_sync = 4'd8;
    localparam logic [3:0] reg_v_bp   = 4'd9;

endpackage

//--- logic/vga_cfg_regs.sv
// Configuration register file with reset defaults and a host write port.

`timescale 1ns/1ns

module vga_cfg_regs (
    input  logic            vga_clk,
    input  logic            rst,
    input  logic            cfg_we,
    input  logic [3:0]      cfg_idx,
    input  logic [15:0]     cfg_wdata,
    output logic            enable,
    output vga_pkg::div_t   clk_div,
    output vga_pkg::shift_t shift,
    output vga_pkg::coord_t h_fp,
    output vga_pkg::coord_t h_vid,
    output vga_pkg::coord_t h_sync,
    output vga_pkg::coord_t h_bp,
    output vga_pkg::coord_t v_fp,
    output vga_pkg::coord_t v_vid,
    output vga_pkg::coord_t v_sync,
    output vga_pkg::coord_t v_bp
);
    vga_pkg::div_t   wr_div;
    vga_pkg::coord_t wr_coord;

    // A written zero divider is stored as one.
    assign wr_div   = (cfg_wdata[6:1] == '0) ? vga_pkg::div_t'(1) : cfg_wdata[6:1];
    assign wr_coord = cfg_wdata[9:0];

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            enable  <= 1'b0;
            clk_div <= vga_pkg::div_t'(1);
            shift   <= '0;
            h_fp    <= vga_pkg::coord_t'(40);
            h_vid   <= vga_pkg::coord_t'(800);
            h_sync  <= vga_pkg::coord_t'(128);
            h_bp    <= vga_pkg::coord_t'(88);
            v_fp    <= vga_pkg::coord_t'(1);
            v_vid   <= vga_pkg::coord_t'(600);
            v_sync  <= vga_pkg::coord_t'(4);
            v_bp    <= vga_pkg::coord_t'(23);
        end else if (cfg_we) begin
            case (cfg_idx)
                vga_pkg::reg_ctrl: begin
                    enable  <= cfg_wdata[0];
                    clk_div <= wr_div;
                end
                vga_pkg::reg_shift:  shift  <= cfg_wdata[2:0];
                vga_pkg::reg_h_fp:   h_fp   <= wr_coord;
                vga_pkg::reg_h_vid:  h_vid  <= wr_coord;
                vga_pkg::reg_h_sync: h_sync <= wr_coord;
                vga_pkg::reg_h_bp:   h_bp   <= wr_coord;
                vga_pkg::reg_v_fp:   v_fp   <= wr_coord;
                vga_pkg::reg_v_vid:  v_vid  <= wr_coord;
                vga_pkg::reg_v_sync: v_sync <= wr_coord;
                vga_pkg::reg_v_bp:   v_bp   <= wr_coord;
                // Unmapped indices are ignored.
                default: ;
            endcase
        end
    end

endmodule

//--- logic/vga_timing_gen.sv
// Pixel tick divider, horizontal and vertical phase machines, coordinates and sync levels.

`timescale 1ns/1ns

module vga_timing_gen (
    input  logic            vga_clk,
    input  logic            rst,
    input  logic            enable,
    input  vga_pkg::div_t   clk_div,
    input  vga_pkg::coord_t h_fp,
    input  vga_pkg::coord_t h_vid,
    input  vga_pkg::coord_t h_sync,
    input  vga_pkg::coord_t h_bp,
    input  vga_pkg::coord_t v_fp,
    input  vga_pkg::coord_t v_vid,
    input  vga_pkg::coord_t v_sync,
    input  vga_pkg::coord_t v_bp,
    output vga_pkg::coord_t pix_x,
    output vga_pkg::coord_t pix_y,
    output logic            vis,
    output logic            hs,
    output logic            vs
);
    vga_pkg::div_t   div_cnt;
    logic            tick;
    logic            line_end;
    vga_pkg::phase_e h_phase;
    vga_pkg::phase_e h_next;
    vga_pkg::phase_e v_phase;
    vga_pkg::phase_e v_next;
    vga_pkg::coord_t h_cnt;
    vga_pkg::coord_t v_cnt;

    // Length in ticks (or lines) of a phase.
    function automatic vga_pkg::coord_t phase_len(
        input vga_pkg::phase_e p,
        input vga_pkg::coord_t vid,
        input vga_pkg::coord_t fp,
        input vga_pkg::coord_t sync,
        input vga_pkg::coord_t bp
    );
        case (p)
            vga_pkg::ph_video: phase_len = vid;
            vga_pkg::ph_fp:    phase_len = fp;
            vga_pkg::ph_sync:  phase_len = sync;
            default:           phase_len = bp;
        endcase
    endfunction

    // Phases wrap from back porch to video.
    assign h_next = vga_pkg::phase_e'(h_phase + 2'd1);
    assign v_next = vga_pkg::phase_e'(v_phase + 2'd1);

    // One tick every clk_div+1 cycles.
    assign tick     = enable && (div_cnt == clk_div);
    assign line_end = tick && (h_phase == vga_pkg::ph_bp) && (h_cnt == '0);

    always_ff @(posedge vga_clk) begin
        if (rst || !enable) begin
            div_cnt <= '0;
            h_phase <= vga_pkg::ph_video;
            v_phase <= vga_pkg::ph_video;
            h_cnt   <= h_vid - 1'b1;
            v_cnt   <= v_vid - 1'b1;
            pix_x   <= '0;
            pix_y   <= '0;
        end else if (tick) begin
            div_cnt <= '0;
            if (h_cnt == '0) begin
                h_phase <= h_next;
                h_cnt   <= phase_len(h_next, h_vid, h_fp, h_sync, h_bp) - 1'b1;
            end else begin
                h_cnt <= h_cnt - 1'b1;
            end
            if (h_phase == vga_pkg::ph_video && h_cnt != '0) begin
                pix_x <= pix_x + 1'b1;
            end else if (line_end) begin
                pix_x <= '0;
            end
            // Vertical machine steps once per line.
            if (line_end) begin
                if (v_cnt == '0) begin
                    v_phase <= v_next;
                    v_cnt   <= phase_len(v_next, v_vid, v_fp, v_sync, v_bp) - 1'b1;
                end else begin
                    v_cnt <= v_cnt - 1'b1;
                end
                if (v_phase == vga_pkg::ph_video && v_cnt != '0) begin
                    pix_y <= pix_y + 1'b1;
                end else if (v_phase == vga_pkg::ph_bp && v_cnt == '0) begin
                    pix_y <= '0;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Levels follow the phase registers and drop as soon as enable does.
    assign vis = enable && (h_phase == vga_pkg::ph_video) && (v_phase == vga_pkg::ph_video);
    assign hs  = enable && (h_phase == vga_pkg::ph_sync);
    assign vs  = enable && (v_phase == vga_pkg::ph_sync);

endmodule

//--- logic/vga_fetch_addr.sv
// First pipeline stage: zoom scaling, video RAM word address and half select.

`timescale 1ns/1ns

module vga_fetch_addr #(
    parameter int vram_aw = 14
) (
    input  logic               vga_clk,
    input  logic               rst,
    input  vga_pkg::shift_t    shift,
    input  vga_pkg::coord_t    pix_x,
    input  vga_pkg::coord_t    pix_y,
    input  logic               vis,
    input  logic               hs,
    input  logic               vs,
    output logic [vram_aw-1:0] rd_addr,
    output logic               half,
    output logic               vis_q,
    output logic               hs_q,
    output logic               vs_q
);
    // Address bits taken from each scaled coordinate.
    localparam int coord_aw = vram_aw / 2;

    vga_pkg::coord_t xs;
    vga_pkg::coord_t ys;

    assign xs = pix_x >> shift;
    assign ys = pix_y >> shift;

    // Two pixels per word, so x drops its low bit.
    always_ff @(posedge vga_clk) begin
        rd_addr <= {ys[coord_aw-1:0], xs[coord_aw:1]};
        half    <= xs[0];
    end

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            vis_q <= 1'b0;
            hs_q  <= 1'b0;
            vs_q  <= 1'b0;
        end else begin
            vis_q <= vis;
            hs_q  <= hs;
            vs_q  <= vs;
        end
    end

endmodule

//--- logic/vga_vram.sv
// Video RAM: simple dual port, host write port and registered read with side signals.

`timescale 1ns/1ns

module vga_vram #(
    parameter int vram_aw = 14
) (
    input  logic               vga_clk,
    input  logic               mem_we,
    input  logic [vram_aw-1:0] mem_addr,
    input  logic [31:0]        mem_wdata,
    input  logic [vram_aw-1:0] rd_addr,
    input  logic               half,
    input  logic               vis,
    input  logic               hs,
    input  logic               vs,
    output logic [31:0]        rd_data,
    output logic               half_q,
    output logic               vis_q,
    output logic               hs_q,
    output logic               vs_q
);
    logic [31:0] mem [2**vram_aw];

    always_ff @(posedge vga_clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // Read sees the word from before a same-cycle write.
    always_ff @(posedge vga_clk) begin
        rd_data <= mem[rd_addr];
    end

    // Side signals stay aligned with the read word.
    always_ff @(posedge vga_clk) begin
        half_q <= half;
        vis_q  <= vis;
        hs_q   <= hs;
        vs_q   <= vs;
    end

endmodule

//--- logic/vga_pixel_out.sv
// Output stage: half select, 4:4:4 to 8-bit colour expansion, blanking and output registers.

`timescale 1ns/1ns

module vga_pixel_out (
    input  logic           vga_clk,
    input  logic           rst,
    input  logic [31:0]    rd_data,
    input  logic           half,
    input  logic           vis,
    input  logic           hs,
    input  logic           vs,
    output vga_pkg::chan_t r,
    output vga_pkg::chan_t g,
    output vga_pkg::chan_t b,
    output logic           hsync,
    output logic           vsync,
    output logic           de
);
    vga_pkg::rgb12_t pix;

    // Odd pixel sits in the upper half of the word.
    assign pix = half ? rd_data[27:16] : rd_data[11:0];

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            r     <= '0;
            g     <= '0;
            b     <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
        end else begin
            hsync <= hs;
            vsync <= vs;
            de    <= vis;
            if (vis) begin
                r <= {pix[11:8], 4'b0000};
                g <= {pix[7:4], 4'b0000};
                b <= {pix[3:0], 4'b0000};
            end else begin
                // Blanking.
                r <= '0;
                g <= '0;
                b <= '0;
            end
        end
    end

endmodule

//--- logic/vga_periph_top.sv
// VGA peripheral top level: config registers, timing generator and three pipeline stages.

`timescale 1ns/1ns

module vga_periph_top #(
    parameter int vram_aw = 14
) (
    input  logic               vga_clk,
    input  logic               rst,
    input  logic               cfg_we,
    input  logic [3:0]         cfg_idx,
    input  logic [15:0]        cfg_wdata,
    input  logic               mem_we,
    input  logic [vram_aw-1:0] mem_addr,
    input  logic [31:0]        mem_wdata,
    output vga_pkg::chan_t     r,
    output vga_pkg::chan_t     g,
    output vga_pkg::chan_t     b,
    output logic               hsync,
    output logic               vsync,
    output logic               de
);
    logic               enable;
    vga_pkg::div_t      clk_div;
    vga_pkg::shift_t    shift;
    vga_pkg::coord_t    h_fp;
    vga_pkg::coord_t    h_vid;
    vga_pkg::coord_t    h_sync;
    vga_pkg::coord_t    h_bp;
    vga_pkg::coord_t    v_fp;
    vga_pkg::coord_t    v_vid;
    vga_pkg::coord_t    v_sync;
    vga_pkg::coord_t    v_bp;

    // Timing generator outputs.
    vga_pkg::coord_t    pix_x;
    vga_pkg::coord_t    pix_y;
    logic               tg_vis;
    logic               tg_hs;
    logic               tg_vs;

    // Fetch stage outputs.
    logic [vram_aw-1:0] rd_addr;
    logic               fa_half;
    logic               fa_vis;
    logic               fa_hs;
    logic               fa_vs;

    // RAM stage outputs.
    logic [31:0]        rd_data;
    logic               rm_half;
    logic               rm_vis;
    logic               rm_hs;
    logic               rm_vs;

    vga_cfg_regs cfg_regs (
        .vga_clk, .rst, .cfg_we, .cfg_idx, .cfg_wdata,
        .enable, .clk_div, .shift,
        .h_fp, .h_vid, .h_sync, .h_bp,
        .v_fp, .v_vid, .v_sync, .v_bp
    );

    vga_timing_gen timing_gen (
        .vga_clk, .rst, .enable, .clk_div,
        .h_fp, .h_vid, .h_sync, .h_bp,
        .v_fp, .v_vid, .v_sync, .v_bp,
        .pix_x, .pix_y, .vis(tg_vis), .hs(tg_hs), .vs(tg_vs)
    );

    vga_fetch_addr #(.vram_aw(vram_aw)) fetch_addr (
        .vga_clk, .rst, .shift, .pix_x, .pix_y,
        .vis(tg_vis), .hs(tg_hs), .vs(tg_vs),
        .rd_addr, .half(fa_half), .vis_q(fa_vis), .hs_q(fa_hs), .vs_q(fa_vs)
    );

    vga_vram #(.vram_aw(vram_aw)) vram (
        .vga_clk, .mem_we, .mem_addr, .mem_wdata,
        .rd_addr, .half(fa_half), .vis(fa_vis), .hs(fa_hs), .vs(fa_vs),
        .rd_data, .half_q(rm_half), .vis_q(rm_vis), .hs_q(rm_hs), .vs_q(rm_vs)
    );

    vga_pixel_out pixel_out (
        .vga_clk, .rst, .rd_data,
        .half(rm_half), .vis(rm_vis), .hs(rm_hs), .vs(rm_vs),
        .r, .g, .b, .hsync, .vsync, .de
    );

endmodule

//--- tb/tb_vga_periph.sv
// VGA peripheral testbench with clock, stimulus table, reference model, checks and watchdog.

`timescale 1ns/1ns

module tb_vga_periph;

    localparam int n_rows = 5;
    // Each row holds divider, shift, then h_vid, h_fp, h_sync, h_bp,
    // v_vid, v_fp, v_sync, v_bp and the number of frames.
    localparam int rows [n_rows][11] = '{
        '{1, 0,  8, 2, 3, 2,  4, 1, 2, 1, 2},
        '{2, 1, 12, 2, 3, 2,  6, 1, 2, 1, 2},
        '{3, 2, 16, 3, 4, 2,  8, 2, 3, 1, 1},
        '{1, 0, 24, 2, 2, 3, 12, 1, 1, 2, 1},
        '{0, 1,  8, 2, 3, 2,  4, 1, 2, 1, 1}
    };

    logic           vga_clk;
    logic           rst;
    logic           cfg_we;
    logic [3:0]     cfg_idx;
    logic [15:0]    cfg_wdata;
    logic           mem_we;
    logic [7:0]     mem_addr;
    logic [31:0]    mem_wdata;
    vga_pkg::chan_t r;
    vga_pkg::chan_t g;
    vga_pkg::chan_t b;
    logic           hsync;
    logic           vsync;
    logic           de;

    logic [31:0] ram_copy [256];
    int          check_cnt;
    int          fail_cnt;

    vga_periph_top #(.vram_aw(8)) uut (
        .vga_clk, .rst, .cfg_we, .cfg_idx, .cfg_wdata,
        .mem_we, .mem_addr, .mem_wdata,
        .r, .g, .b, .hsync, .vsync, .de
    );

    initial begin
        vga_clk = 1'b0;
        forever #2 vga_clk = ~vga_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Cycles per pixel tick for a written divider value.
    function automatic int pixel_period(input int d);
        if (d == 0) begin
            return 2;
        end
        return d + 1;
    endfunction

    // Phase of a position within a line or a frame.
    function automatic vga_pkg::phase_e phase_of(input int pos, input int vid, input int fp,
                                                 input int sync);
        if (pos < vid) return vga_pkg::ph_video;
        else if (pos < vid + fp) return vga_pkg::ph_fp;
        else if (pos < vid + fp + sync) return vga_pkg::ph_sync;
        else return vga_pkg::ph_bp;
    endfunction

    // Expected 8-bit channels of a visible pixel with red in the top byte.
    function automatic logic [23:0] expected_rgb(input int x, input int y, input int s);
        int          xs;
        int          ys;
        int          addr;
        logic [31:0] word;
        logic [11:0] pix;
        xs = x >> s;
        ys = y >> s;
        addr = (ys % 16) * 16 + (xs / 2) % 16;
        word = ram_copy[addr];
        pix = (xs % 2 == 1) ? word[27:16] : word[11:0];
        return {pix[11:8], 4'h0, pix[7:4], 4'h0, pix[3:0], 4'h0};
    endfunction

    function automatic int run_cycles();
        int total;
        int i;
        total = 256 + 40;
        for (i = 0; i < n_rows; i++) begin
            total += rows[i][10] * (rows[i][2] + rows[i][3] + rows[i][4] + rows[i][5])
                     * (rows[i][6] + rows[i][7] + rows[i][8] + rows[i][9])
                     * pixel_period(rows[i][0]) + 20;
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        assert (exp == act) else begin
            $display("ERR %s expected 0x%0h actual 0x%0h at %0t ns", name, exp, act, $time);
            fail_cnt++;
        end
    endtask

    task automatic compare_outputs(input logic exp_hs, input logic exp_vs, input logic exp_de,
                                   input logic [23:0] exp_rgb);
        check_value("hsync", 32'(exp_hs), 32'(hsync));
        check_value("vsync", 32'(exp_vs), 32'(vsync));
        check_value("de", 32'(exp_de), 32'(de));
        check_value("r", 32'(exp_rgb[23:16]), 32'(r));
        check_value("g", 32'(exp_rgb[15:8]), 32'(g));
        check_value("b", 32'(exp_rgb[7:0]), 32'(b));
    endtask

    // Called on a falling edge; the write lands on the next rising edge.
    task automatic drive_cfg(input logic [3:0] idx, input logic [15:0] data);
        cfg_we    = 1'b1;
        cfg_idx   = idx;
        cfg_wdata = data;
        @(negedge vga_clk);
        cfg_we = 1'b0;
    endtask

    task automatic check_idle(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            compare_outputs(1'b0, 1'b0, 1'b0, 24'h0);
            @(negedge vga_clk);
        end
    endtask

    task automatic run_row(input int row);
        int   d;
        int   s;
        int   per;
        int   hl;
        int   vl;
        int   steps;
        int   c;
        int   t;
        int   f;
        int   hx;
        int   ly;
        int   hs_rise;
        int   vs_rise;
        int   de_cnt;
        int   err0;
        logic hs_prev;
        logic vs_prev;
        logic exp_hs;
        logic exp_vs;
        logic exp_de;
        logic [23:0] exp_rgb;
        d = rows[row][0];
        s = rows[row][1];
        per = pixel_period(d);
        hl = rows[row][2] + rows[row][3] + rows[row][4] + rows[row][5];
        vl = rows[row][6] + rows[row][7] + rows[row][8] + rows[row][9];
        steps = rows[row][10] * hl * vl * per;
        err0 = fail_cnt;
        drive_cfg(vga_pkg::reg_ctrl, 16'h0002);
        drive_cfg(vga_pkg::reg_shift, 16'(s));
        drive_cfg(vga_pkg::reg_h_vid, 16'(rows[row][2]));
        drive_cfg(vga_pkg::reg_h_fp, 16'(rows[row][3]));
        drive_cfg(vga_pkg::reg_h_sync, 16'(rows[row][4]));
        drive_cfg(vga_pkg::reg_h_bp, 16'(rows[row][5]));
        drive_cfg(vga_pkg::reg_v_vid, 16'(rows[row][6]));
        drive_cfg(vga_pkg::reg_v_fp, 16'(rows[row][7]));
        drive_cfg(vga_pkg::reg_v_sync, 16'(rows[row][8]));
        drive_cfg(vga_pkg::reg_v_bp, 16'(rows[row][9]));
        drive_cfg(vga_pkg::reg_ctrl, 16'((d << 1) | 1));
        hs_rise = -1;
        vs_rise = -1;
        hs_prev = 1'b0;
        vs_prev = 1'b0;
        de_cnt = 0;
        // Outputs at cycle c show the timing state three cycles earlier.
        for (c = 0; c < steps + 3; c++) begin
            exp_hs = 1'b0;
            exp_vs = 1'b0;
            exp_de = 1'b0;
            exp_rgb = 24'h0;
            if (c >= 3) begin
                t = c - 3;
                f = (t / per) % (hl * vl);
                hx = f % hl;
                ly = f / hl;
                exp_hs = phase_of(hx, rows[row][2], rows[row][3], rows[row][4])
                         == vga_pkg::ph_sync;
                exp_vs = phase_of(ly, rows[row][6], rows[row][7], rows[row][8])
                         == vga_pkg::ph_sync;
                exp_de = hx < rows[row][2] && ly < rows[row][6];
                if (exp_de) exp_rgb = expected_rgb(hx, ly, s);
            end
            compare_outputs(exp_hs, exp_vs, exp_de, exp_rgb);
            if (hsync && !hs_prev) begin
                if (hs_rise >= 0) check_value("hsync period", 32'(hl * per), 32'(c - hs_rise));
                hs_rise = c;
            end
            if (!hsync && hs_prev && hs_rise >= 0) begin
                check_value("hsync width", 32'(rows[row][4] * per), 32'(c - hs_rise));
            end
            if (vsync && !vs_prev) begin
                if (vs_rise >= 0) begin
                    check_value("vsync period", 32'(hl * vl * per), 32'(c - vs_rise));
                end
                vs_rise = c;
            end
            if (!vsync && vs_prev && vs_rise >= 0) begin
                check_value("vsync width", 32'(rows[row][8] * hl * per), 32'(c - vs_rise));
            end
            hs_prev = hsync;
            vs_prev = vsync;
            if (de) de_cnt++;
            @(negedge vga_clk);
        end
        check_value("de cycles", 32'(rows[row][10] * rows[row][2] * rows[row][6] * per),
                    32'(de_cnt));
        $display("row %0d: div %0d shift %0d line %0d frame %0d lines, %0d errors",
                 row, d, s, hl, vl, fail_cnt - err0);
    endtask

    initial begin
        int          a;
        int          row;
        logic [31:0] seed;
        rst       = 1'b1;
        cfg_we    = 1'b0;
        cfg_idx   = '0;
        cfg_wdata = '0;
        mem_we    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        check_cnt = 0;
        fail_cnt  = 0;
        seed      = 32'h64a3;
        repeat (2) @(posedge vga_clk);
        @(negedge vga_clk);
        rst = 1'b0;
        // Fill the RAM while the display is still disabled.
        for (a = 0; a < 256; a++) begin
            seed = xorshift32(seed);
            ram_copy[a] = seed;
            mem_we    = 1'b1;
            mem_addr  = 8'(a);
            mem_wdata = seed;
            check_idle(1);
        end
        mem_we = 1'b0;
        for (row = 0; row < n_rows; row++) begin
            run_row(row);
        end
        drive_cfg(vga_pkg::reg_ctrl, 16'h0002);
        repeat (3) @(negedge vga_clk);
        check_idle(8);
        $display("checks passed %0d failed %0d", check_cnt - fail_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = run_cycles() + 500;
        repeat (limit) @(posedge vga_clk);
        $display("Watchdog: run timed out after %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- tb.f
logic/vga_pkg.sv
logic/vga_cfg_regs.sv
logic/vga_timing_gen.sv
logic/vga_fetch_addr.sv
logic/vga_vram.sv
logic/vga_pixel_out.sv
logic/vga_periph_top.sv
tb/tb_vga_periph.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the VGA peripheral testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_vga_periph \
    -Mdir obj_dir \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
